// ==== adc16_pkg.sv ====
//==========================================================
// adc16 shared definitions.
// register map, control and 3-wire field layouts, and the
// command and strobe bundles used across the controller.
//==========================================================
`default_nettype none

package adc16_pkg;

  // one opb data word.
  // index 0 is the msb as on the bus, so opb bit 0 is word bit 31.
  typedef logic [0:31] opb_word_t;

  // byte offsets of the two registers, decoded on address bit 2.
  localparam logic [31:0] reg_offset_3wire = 32'h0000_0000;
  localparam logic [31:0] reg_offset_ctrl  = 32'h0000_0004;

  // bits in one serial command, address then data.
  localparam int unsigned cmd_frame_bits = 24;

  // control register at offset 4.
  typedef struct packed {
    logic [15:0] delay_rst;  // opb bits 0-15.
    logic [4:0]  delay_tap;  // opb bits 16-20.
    logic [3:0]  bitslip;    // opb bits 21-24.
    logic [3:0]  pad_25;
    logic        adc_reset;  // opb bit 29.
    logic        pad_30;
    logic        snap_req;   // opb bit 31.
  } adc_ctrl_t;

  // offset 0 seen as direct pin control.
  typedef struct packed {
    logic        sclk;       // opb bit 0.
    logic        sdata;      // opb bit 1.
    logic [3:0]  csn;        // opb bits 2-5, active low.
    logic        cmd_mode;   // opb bit 6, low in this view.
    logic [24:0] spare;
  } bitbang_t;

  // offset 0 seen as a serial command.
  typedef struct packed {
    logic [1:0]  spare;      // ignored here.
    logic [3:0]  chip_mask;  // opb bits 2-5, high selects a chip.
    logic        cmd_mode;   // opb bit 6, high in this view.
    logic        go;         // opb bit 7.
    logic [7:0]  address;    // opb bits 8-15.
    logic [15:0] data;       // opb bits 16-31.
  } serial_cmd_t;

  // cmd_mode sits at the same bit in both views and picks the decode.
  typedef union packed {
    bitbang_t    bb;
    serial_cmd_t ser;
    opb_word_t   raw;
  } adc3wire_word_u;

  // the six 3-wire pins.
  typedef struct packed {
    logic       sclk;
    logic       sdata;
    logic [3:0] csn;
  } adc3wire_pins_t;

  // new control word plus a one-cycle write valid.
  typedef struct packed {
    adc_ctrl_t ctrl;
    logic      wr;
  } strobe_t;

  // command handed to the engine, stable while req is high.
  typedef struct packed {
    logic [3:0]  chip_mask;
    logic [7:0]  address;
    logic [15:0] data;
  } cmd_t;

endpackage

`default_nettype wire

// ==== opb_adc16_slave.sv ====
//==========================================================
// opb adc16 slave.
// decodes the opb window, keeps the 3-wire and control
// registers with byte enables, acks each access once and
// issues serial commands to the 3-wire engine.
//==========================================================
`default_nettype none

module opb_adc16_slave #(
  parameter logic [31:0] base_addr = 32'h0000_0000,
  parameter logic [31:0] high_addr = 32'h0000_ffff
) (
  input  wire                            OPB_Clk,
  input  wire                            rst_n,
  input  wire adc16_pkg::opb_word_t      opb_abus,
  input  wire [0:3]                      opb_be,
  input  wire adc16_pkg::opb_word_t      opb_dbus,
  input  wire                            opb_rnw,
  input  wire                            opb_select,
  input  wire [1:0]                      roach2_rev,
  input  wire                            cmd_ack,
  input  wire                            engine_busy,
  output adc16_pkg::opb_word_t           sl_dbus,
  output logic                           sl_xfer_ack,
  output logic                           cmd_req,
  output adc16_pkg::cmd_t                cmd,
  output adc16_pkg::strobe_t             strobe,
  output adc16_pkg::adc3wire_word_u      adc3wire_word
);
  import adc16_pkg::*;

  // register state.
  logic           ack_q;
  adc3wire_word_u wire_q;
  adc_ctrl_t      ctrl_q;
  opb_word_t      rdata_q;
  logic           strobe_wr;

  // decode.
  logic [31:0]    addr_off;
  logic           addr_hit;
  logic           hit_3wire;
  logic           hit_ctrl;
  logic           access;
  logic           wr_3wire;
  logic           wr_ctrl;
  logic           rd_access;

  // offset 0 write path and read-back.
  adc3wire_word_u wire_next;
  adc3wire_word_u wire_store;
  adc3wire_word_u rd_3wire;
  logic           busy;
  logic           go_req;

  // merge the enabled bytes of a write into the old word.
  // be[0] covers opb bits 0-7.
  function automatic opb_word_t merge_bytes(opb_word_t old_word, opb_word_t new_word,
                                            logic [0:3] be);
    opb_word_t merged;
    merged = old_word;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        merged[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return merged;
  endfunction

  assign addr_hit  = (opb_abus >= base_addr) && (opb_abus <= high_addr);
  assign addr_off  = opb_abus - base_addr;
  // other in-window offsets fold onto the two registers.
  assign hit_3wire = (addr_off[2] == reg_offset_3wire[2]);
  assign hit_ctrl  = (addr_off[2] == reg_offset_ctrl[2]);
  // no new access in our own ack cycle.
  assign access    = addr_hit && opb_select && !ack_q;
  assign wr_3wire  = access && !opb_rnw && hit_3wire;
  assign wr_ctrl   = access && !opb_rnw && hit_ctrl;
  assign rd_access = access && opb_rnw;

  // a pending request counts as busy until the engine takes it.
  assign busy      = engine_busy || cmd_req;
  assign wire_next.raw = merge_bytes(wire_q.raw, opb_dbus, opb_be);
  assign go_req    = wire_next.ser.cmd_mode && wire_next.ser.go && !busy;

  always_comb begin
    // go never lands in the register.
    wire_store        = wire_next;
    wire_store.ser.go = 1'b0;
    // read-back shows busy at bit 7 and the board revision at 30-31.
    rd_3wire             = wire_q;
    rd_3wire.ser.go      = busy;
    rd_3wire.raw[30:31]  = roach2_rev;
  end

  //==========================================================
  // control state
  //==========================================================
  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      ack_q     <= 1'b0;
      wire_q    <= '0;
      ctrl_q    <= '0;
      cmd_req   <= 1'b0;
      strobe_wr <= 1'b0;
    end else begin
      ack_q     <= access;
      strobe_wr <= wr_ctrl;
      if (wr_3wire) begin
        wire_q <= wire_store;
      end
      if (wr_ctrl) begin
        ctrl_q <= adc_ctrl_t'(merge_bytes(opb_word_t'(ctrl_q), opb_dbus, opb_be));
      end
      // four-phase handshake, req falls once the engine acks.
      if (cmd_ack) begin
        cmd_req <= 1'b0;
      end else if (wr_3wire && go_req) begin
        cmd_req <= 1'b1;
      end
    end
  end

  // read data and the latched command.
  always_ff @(posedge OPB_Clk) begin
    if (rd_access) begin
      rdata_q <= hit_ctrl ? opb_word_t'(ctrl_q) : rd_3wire.raw;
    end
    if (wr_3wire && go_req) begin
      cmd.chip_mask <= wire_next.ser.chip_mask;
      cmd.address   <= wire_next.ser.address;
      cmd.data      <= wire_next.ser.data;
    end
  end

  assign sl_xfer_ack   = ack_q;
  // bus is quiet outside the ack cycle.
  assign sl_dbus       = ack_q ? rdata_q : '0;
  assign strobe        = '{ctrl: ctrl_q, wr: strobe_wr};
  assign adc3wire_word = wire_q;

endmodule

`default_nettype wire

// ==== adc3wire_engine.sv ====
//==========================================================
// adc 3-wire serial engine.
// shifts a 24-bit address and data frame out to the masked
// chips, or passes the bit-banged pins through.
//==========================================================
`default_nettype none

module adc3wire_engine #(
  parameter int unsigned sclk_div = 4
) (
  input  wire                            OPB_Clk,
  input  wire                            rst_n,
  input  wire                            cmd_req,
  input  wire adc16_pkg::cmd_t           cmd,
  input  wire adc16_pkg::adc3wire_word_u adc3wire_word,
  output logic                           cmd_ack,
  output logic                           engine_busy,
  output adc16_pkg::adc3wire_pins_t      pins
);
  import adc16_pkg::*;

  localparam int unsigned div_w = (sclk_div > 1) ? $clog2(sclk_div) : 1;
  localparam logic [div_w-1:0] div_last = div_w'(sclk_div - 1);
  localparam int unsigned bit_w = $clog2(cmd_frame_bits);
  localparam logic [bit_w-1:0] bit_last = bit_w'(cmd_frame_bits - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_shift,
    st_done
  } state_t;

  state_t                    state;
  logic [div_w-1:0]          div_cnt;
  logic [bit_w-1:0]          bit_cnt;
  logic [cmd_frame_bits-1:0] shreg;
  logic                      ser_sclk;
  logic [3:0]                ser_csn;
  logic                      bb_armed;
  logic                      bb_live;
  logic                      half_end;

  // end of one sclk half-period.
  assign half_end = (div_cnt == div_last);

  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      state    <= st_idle;
      cmd_ack  <= 1'b0;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      shreg    <= '0;
      ser_sclk <= 1'b0;
      ser_csn  <= '1;
      bb_armed <= 1'b0;
    end else begin
      if (adc3wire_word.raw != '0) begin
        bb_armed <= 1'b1;
      end
      case (state)
        st_idle: begin
          div_cnt  <= '0;
          bit_cnt  <= '0;
          ser_sclk <= 1'b0;
          // take the command, ack it and select the chips.
          if (cmd_req) begin
            cmd_ack <= 1'b1;
            shreg   <= {cmd.address, cmd.data};
            ser_csn <= ~cmd.chip_mask;
            state   <= st_shift;
          end
        end
        st_shift: begin
          if (half_end) begin
            div_cnt  <= '0;
            ser_sclk <= !ser_sclk;
            // falling sclk moves to the next bit.
            if (ser_sclk) begin
              shreg <= {shreg[cmd_frame_bits-2:0], 1'b0};
              if (bit_cnt == bit_last) begin
                ser_csn <= '1;
                state   <= st_done;
              end else begin
                bit_cnt <= bit_cnt + 1'b1;
              end
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        st_done: begin
          // hold ack until req has gone away.
          if (!cmd_req) begin
            cmd_ack <= 1'b0;
            state   <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign engine_busy = (state != st_idle);

  // pins stay deselected until the 3-wire register first holds a value.
  assign bb_live = bb_armed || (adc3wire_word.raw != '0);

  always_comb begin
    if (!adc3wire_word.bb.cmd_mode && bb_live) begin
      pins.sclk  = adc3wire_word.bb.sclk;
      pins.sdata = adc3wire_word.bb.sdata;
      pins.csn   = adc3wire_word.bb.csn;
    end else begin
      pins.sclk  = ser_sclk;
      pins.sdata = shreg[cmd_frame_bits-1];
      pins.csn   = ser_csn;
    end
  end

endmodule

`default_nettype wire

// ==== adc_strobe_gen.sv ====
//==========================================================
// adc control strobe generator.
// turns control register writes into one-cycle bitslip and
// delay reset pulses and held control levels.
//==========================================================
`default_nettype none

module adc_strobe_gen (
  input  wire                     OPB_Clk,
  input  wire                     rst_n,
  input  wire adc16_pkg::strobe_t strobe,
  output logic [15:0]             delay_rst,
  output logic [4:0]              delay_tap,
  output logic [3:0]              bitslip,
  output logic                    adc_reset,
  output logic                    snap_req
);

  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      delay_rst <= '0;
      bitslip   <= '0;
      delay_tap <= '0;
      adc_reset <= 1'b0;
      snap_req  <= 1'b0;
    end else begin
      // one write gives one slip and one delay reset.
      delay_rst <= strobe.wr ? strobe.ctrl.delay_rst : '0;
      bitslip   <= strobe.wr ? strobe.ctrl.bitslip : '0;
      // levels follow the last written word.
      if (strobe.wr) begin
        delay_tap <= strobe.ctrl.delay_tap;
        adc_reset <= strobe.ctrl.adc_reset;
        snap_req  <= strobe.ctrl.snap_req;
      end
    end
  end

endmodule

`default_nettype wire

// ==== opb_adc16_ctrl.sv ====
//==========================================================
// opb adc16 controller top level.
// joins the opb slave, the 3-wire engine and the strobe
// generator to the bus and the adc board pins.
//==========================================================
`default_nettype none

module opb_adc16_ctrl #(
  parameter logic [31:0] base_addr = 32'h0000_0000,
  parameter logic [31:0] high_addr = 32'h0000_ffff,
  parameter int unsigned sclk_div  = 4
) (
  input  wire                       OPB_Clk,
  input  wire                       rst_n,
  input  wire adc16_pkg::opb_word_t opb_abus,
  input  wire [0:3]                 opb_be,
  input  wire adc16_pkg::opb_word_t opb_dbus,
  input  wire                       opb_rnw,
  input  wire                       opb_select,
  input  wire [1:0]                 adc0_roach2_rev,
  output adc16_pkg::opb_word_t      sl_dbus,
  output logic                      sl_err_ack,
  output logic                      sl_retry,
  output logic                      sl_tout_sup,
  output logic                      sl_xfer_ack,
  output logic                      adc0_adc3wire_sclk,
  output logic                      adc0_adc3wire_sdata,
  output logic [3:0]                adc0_adc3wire_csn,
  output logic [15:0]               adc0_delay_rst,
  output logic [4:0]                adc0_delay_tap,
  output logic [3:0]                adc0_iserdes_bitslip,
  output logic                      adc0_reset,
  output logic                      adc0_snap_req
);
  import adc16_pkg::*;

  logic           cmd_req;
  logic           cmd_ack;
  logic           engine_busy;
  cmd_t           cmd;
  strobe_t        strobe;
  adc3wire_word_u adc3wire_word;
  adc3wire_pins_t pins;

  opb_adc16_slave #(
    .base_addr (base_addr),
    .high_addr (high_addr)
  ) u_slave (
    .OPB_Clk       (OPB_Clk),
    .rst_n         (rst_n),
    .opb_abus      (opb_abus),
    .opb_be        (opb_be),
    .opb_dbus      (opb_dbus),
    .opb_rnw       (opb_rnw),
    .opb_select    (opb_select),
    .roach2_rev    (adc0_roach2_rev),
    .cmd_ack       (cmd_ack),
    .engine_busy   (engine_busy),
    .sl_dbus       (sl_dbus),
    .sl_xfer_ack   (sl_xfer_ack),
    .cmd_req       (cmd_req),
    .cmd           (cmd),
    .strobe        (strobe),
    .adc3wire_word (adc3wire_word)
  );

  adc3wire_engine #(
    .sclk_div (sclk_div)
  ) u_engine (
    .OPB_Clk       (OPB_Clk),
    .rst_n         (rst_n),
    .cmd_req       (cmd_req),
    .cmd           (cmd),
    .adc3wire_word (adc3wire_word),
    .cmd_ack       (cmd_ack),
    .engine_busy   (engine_busy),
    .pins          (pins)
  );

  adc_strobe_gen u_strobe (
    .OPB_Clk   (OPB_Clk),
    .rst_n     (rst_n),
    .strobe    (strobe),
    .delay_rst (adc0_delay_rst),
    .delay_tap (adc0_delay_tap),
    .bitslip   (adc0_iserdes_bitslip),
    .adc_reset (adc0_reset),
    .snap_req  (adc0_snap_req)
  );

  assign adc0_adc3wire_sclk  = pins.sclk;
  assign adc0_adc3wire_sdata = pins.sdata;
  assign adc0_adc3wire_csn   = pins.csn;

  // no retry, error or timeout handling on this slave.
  assign sl_err_ack  = 1'b0;
  assign sl_retry    = 1'b0;
  assign sl_tout_sup = 1'b0;

endmodule

`default_nettype wire

// ==== tb_opb_adc16_ctrl.sv ====
//==========================================================
// testbench for the opb adc16 controller.
// drives opb reads and writes, models both registers and
// checks read-back, strobes, bit-bang pins and serial frames.
//==========================================================
`default_nettype none

module tb_opb_adc16_ctrl;
  timeunit 1ns;
  timeprecision 1ps;

  import adc16_pkg::*;

  localparam int unsigned sclk_div    = 4;
  localparam int          ack_timeout = 16;
  localparam int          csn_timeout = 8;
  // one full serial command in clock cycles.
  localparam int          cmd_cycles  = 48 * sclk_div + 2;

  logic           OPB_Clk;
  logic           rst_n;
  opb_word_t      opb_abus;
  logic [0:3]     opb_be;
  opb_word_t      opb_dbus;
  logic           opb_rnw;
  logic           opb_select;
  logic [1:0]     adc0_roach2_rev;
  opb_word_t      sl_dbus;
  logic           sl_err_ack;
  logic           sl_retry;
  logic           sl_tout_sup;
  logic           sl_xfer_ack;
  logic           adc0_adc3wire_sclk;
  logic           adc0_adc3wire_sdata;
  logic [3:0]     adc0_adc3wire_csn;
  logic [15:0]    adc0_delay_rst;
  logic [4:0]     adc0_delay_tap;
  logic [3:0]     adc0_iserdes_bitslip;
  logic           adc0_reset;
  logic           adc0_snap_req;

  // shadow registers with word bit 31 as opb bit 0.
  logic [31:0]    shadow_3w;
  logic [31:0]    shadow_ctrl;
  // set once the 3-wire register has held a nonzero word.
  logic           armed;
  integer         seed;
  // serial monitor state.
  logic           mon_en;
  logic [23:0]    mon_shift;
  logic [23:0]    exp_frame;
  int             mon_bits;
  int             frame_count;

  opb_adc16_ctrl #(
    .base_addr (32'h0000_0000),
    .high_addr (32'h0000_ffff),
    .sclk_div  (sclk_div)
  ) dut0 (
    .OPB_Clk              (OPB_Clk),
    .rst_n                (rst_n),
    .opb_abus             (opb_abus),
    .opb_be               (opb_be),
    .opb_dbus             (opb_dbus),
    .opb_rnw              (opb_rnw),
    .opb_select           (opb_select),
    .adc0_roach2_rev      (adc0_roach2_rev),
    .sl_dbus              (sl_dbus),
    .sl_err_ack           (sl_err_ack),
    .sl_retry             (sl_retry),
    .sl_tout_sup          (sl_tout_sup),
    .sl_xfer_ack          (sl_xfer_ack),
    .adc0_adc3wire_sclk   (adc0_adc3wire_sclk),
    .adc0_adc3wire_sdata  (adc0_adc3wire_sdata),
    .adc0_adc3wire_csn    (adc0_adc3wire_csn),
    .adc0_delay_rst       (adc0_delay_rst),
    .adc0_delay_tap       (adc0_delay_tap),
    .adc0_iserdes_bitslip (adc0_iserdes_bitslip),
    .adc0_reset           (adc0_reset),
    .adc0_snap_req        (adc0_snap_req)
  );

  initial begin
    OPB_Clk = 1'b0;
    forever #5 OPB_Clk = ~OPB_Clk;
  end

  //==========================================================
  // failure reporting and compares
  //==========================================================
  task automatic stop_run();
    $display("TB FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic fail_now(input string why);
    $display("%s", why);
    stop_run();
  endtask

  task automatic check_word(input string name, input opb_word_t got, input opb_word_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_ctrl(input string name, input adc_ctrl_t got, input adc_ctrl_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_pins(input string name, input adc3wire_pins_t got,
                            input adc3wire_pins_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_frame(input string name, input logic [23:0] got, input logic [23:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  //==========================================================
  // reference model
  //==========================================================
  // be bit 3 selects opb lane 0 which is the most significant byte.
  function automatic logic [31:0] merge_ref(input logic [31:0] old_w, input logic [31:0] new_w,
                                            input logic [3:0] be);
    logic [31:0] w;
    w = old_w;
    for (int k = 0; k < 4; k++) begin
      if (be[k]) begin
        w[8*k +: 8] = new_w[8*k +: 8];
      end
    end
    return w;
  endfunction

  // offset 0 shows busy at opb bit 7 and the revision at opb bits 30-31.
  function automatic opb_word_t read_model(input logic [31:0] addr, input logic busy);
    logic [31:0] w;
    if (addr[2]) begin
      w = shadow_ctrl;
    end else begin
      w = shadow_3w;
      w[24] = busy;
      w[1:0] = adc0_roach2_rev;
    end
    return w;
  endfunction

  // pulse fields only in the cycle after the write.
  function automatic adc_ctrl_t strobe_model(input logic pulse);
    adc_ctrl_t c;
    c = '0;
    c.delay_rst = pulse ? shadow_ctrl[31:16] : 16'h0000;
    c.delay_tap = shadow_ctrl[15:11];
    c.bitslip   = pulse ? shadow_ctrl[10:7] : 4'h0;
    c.adc_reset = shadow_ctrl[2];
    c.snap_req  = shadow_ctrl[0];
    return c;
  endfunction

  function automatic adc3wire_pins_t pins_model(input logic frame_start);
    adc3wire_pins_t p;
    if (frame_start) begin
      // sclk low, first address bit out, selected chips low.
      p.sclk  = 1'b0;
      p.sdata = shadow_3w[23];
      p.csn   = ~shadow_3w[29:26];
    end else if (!shadow_3w[25] && armed) begin
      p.sclk  = shadow_3w[31];
      p.sdata = shadow_3w[30];
      p.csn   = shadow_3w[29:26];
    end else begin
      // serial idle and the state before any nonzero write.
      p.sclk  = 1'b0;
      p.sdata = 1'b0;
      p.csn   = 4'hf;
    end
    return p;
  endfunction

  // address byte first, then the data half-word.
  function automatic logic [23:0] frame_of(input logic [31:0] word);
    logic [7:0]  address;
    logic [15:0] data;
    address = word[23:16];
    data    = word[15:0];
    return {address, data};
  endfunction

  function automatic adc_ctrl_t out_ctrl();
    adc_ctrl_t c;
    c = '0;
    c.delay_rst = adc0_delay_rst;
    c.delay_tap = adc0_delay_tap;
    c.bitslip   = adc0_iserdes_bitslip;
    c.adc_reset = adc0_reset;
    c.snap_req  = adc0_snap_req;
    return c;
  endfunction

  function automatic adc3wire_pins_t pins_now();
    adc3wire_pins_t p;
    p.sclk  = adc0_adc3wire_sclk;
    p.sdata = adc0_adc3wire_sdata;
    p.csn   = adc0_adc3wire_csn;
    return p;
  endfunction

  //==========================================================
  // bus tasks
  //==========================================================
  // inputs change 1 ns after the rising edge.
  task automatic tick();
    @(posedge OPB_Clk);
    #1;
  endtask

  task automatic wait_ack(input string what);
    int waited;
    waited = 0;
    tick();
    while (sl_xfer_ack !== 1'b1) begin
      if (waited >= ack_timeout) begin
        fail_now($sformatf("no xfer_ack seen for the %s", what));
      end else begin
        waited = waited + 1;
        tick();
      end
    end
    // retry, error ack and timeout suppression stay low at every ack.
    check_bit("sl_err_ack", sl_err_ack, 1'b0);
    check_bit("sl_retry", sl_retry, 1'b0);
    check_bit("sl_tout_sup", sl_tout_sup, 1'b0);
  endtask

  task automatic opb_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be);
    opb_abus   = addr;
    opb_dbus   = data;
    opb_be     = be;
    opb_rnw    = 1'b0;
    opb_select = 1'b1;
    wait_ack("write");
    opb_select = 1'b0;
    opb_abus   = '0;
    opb_dbus   = '0;
    opb_be     = 4'h0;
  endtask

  task automatic opb_read(input logic [31:0] addr, output opb_word_t data);
    opb_abus   = addr;
    opb_be     = 4'hf;
    opb_rnw    = 1'b1;
    opb_select = 1'b1;
    wait_ack("read");
    data       = sl_dbus;
    opb_select = 1'b0;
    opb_rnw    = 1'b0;
    opb_abus   = '0;
    opb_be     = 4'h0;
    // bus must be quiet again after the ack cycle.
    tick();
    check_word("sl_dbus", sl_dbus, '0);
  endtask

  // update the shadow, then run the bus write.
  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be);
    if (addr[2]) begin
      shadow_ctrl = merge_ref(shadow_ctrl, data, be);
    end else begin
      shadow_3w = merge_ref(shadow_3w, data, be);
      // go is never stored.
      shadow_3w[24] = 1'b0;
      if (shadow_3w != 32'h0) begin
        armed = 1'b1;
      end
    end
    opb_write(addr, data, be);
  endtask

  task automatic read_check(input logic [31:0] addr, input logic busy);
    opb_word_t got;
    opb_read(addr, got);
    check_word("sl_dbus", got, read_model(addr, busy));
  endtask

  // samples sdata on each rising sclk while a chip is selected.
  always @(posedge adc0_adc3wire_sclk) begin
    if (mon_en && adc0_adc3wire_csn != 4'hf) begin
      mon_shift = {mon_shift[22:0], adc0_adc3wire_sdata};
      mon_bits  = mon_bits + 1;
      if (mon_bits == 24) begin
        check_frame("adc0_adc3wire_sdata frame", mon_shift, exp_frame);
        frame_count = frame_count + 1;
        mon_bits    = 0;
      end
    end
  end

  //==========================================================
  // test sequence
  //==========================================================
  task automatic reset_state_checks();
    check_word("sl_dbus", sl_dbus, '0);
    check_pins("adc3wire pins", pins_now(), pins_model(1'b0));
    check_ctrl("strobe outputs", out_ctrl(), strobe_model(1'b0));
    read_check(32'h0000_0000, 1'b0);
    read_check(32'h0000_0004, 1'b0);
  endtask

  task automatic byte_write_sweep();
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] r;
    for (int i = 0; i < 40; i++) begin
      addr = $random(seed);
      // any word address in the window including the aliases.
      addr = addr & 32'h0000_fffc;
      data = $random(seed);
      r    = $random(seed);
      if (!addr[2]) begin
        data[24] = 1'b0;
      end
      reg_write(addr, data, r[3:0]);
      read_check(addr, 1'b0);
    end
    read_check(32'h0000_0000, 1'b0);
    read_check(32'h0000_0004, 1'b0);
  endtask

  task automatic bitbang_pins();
    logic [31:0] data;
    for (int i = 0; i < 8; i++) begin
      data = $random(seed);
      data[25] = 1'b0;
      reg_write(32'h0000_0000, data, 4'hf);
      check_pins("adc3wire pins", pins_now(), pins_model(1'b0));
      tick();
      check_pins("adc3wire pins", pins_now(), pins_model(1'b0));
    end
    read_check(32'h0000_0000, 1'b0);
  endtask

  task automatic control_strobes();
    logic [31:0] data;
    adc_ctrl_t   prev;
    for (int i = 0; i < 6; i++) begin
      data = $random(seed);
      prev = strobe_model(1'b0);
      reg_write(32'h0000_0004, data, 4'hf);
      // outputs are unchanged in the ack cycle.
      check_ctrl("strobe outputs", out_ctrl(), prev);
      tick();
      check_ctrl("strobe outputs", out_ctrl(), strobe_model(1'b1));
      tick();
      check_ctrl("strobe outputs", out_ctrl(), strobe_model(1'b0));
    end
  endtask

  task automatic serial_command();
    logic [31:0] r;
    logic [31:0] word;
    logic [3:0]  mask;
    opb_word_t   got;
    int          waited;
    r    = $random(seed);
    mask = (r[3:0] == 4'h0) ? 4'h1 : r[3:0];
    word = $random(seed);
    word[31:30] = 2'b00;
    word[29:26] = mask;
    word[25]    = 1'b1;
    word[24]    = 1'b1;
    exp_frame   = frame_of(word);
    frame_count = 0;
    mon_bits    = 0;
    mon_en      = 1'b1;
    reg_write(32'h0000_0000, word, 4'hf);
    waited = 0;
    while (adc0_adc3wire_csn == 4'hf) begin
      if (waited >= csn_timeout) begin
        fail_now("chip selects never went low after a serial command");
      end else begin
        waited = waited + 1;
        tick();
      end
    end
    check_pins("adc3wire pins", pins_now(), pins_model(1'b1));
    read_check(32'h0000_0000, 1'b1);
    // a second go while busy is dropped but the other fields still land.
    word = $random(seed);
    word[31:30] = 2'b00;
    word[25]    = 1'b1;
    word[24]    = 1'b1;
    reg_write(32'h0000_0000, word, 4'hf);
    read_check(32'h0000_0000, 1'b1);
    waited = 0;
    opb_read(32'h0000_0000, got);
    while (got[7] !== 1'b0) begin
      if (waited >= cmd_cycles) begin
        fail_now("busy never cleared after a serial command");
      end else begin
        waited = waited + 1;
        opb_read(32'h0000_0000, got);
      end
    end
    read_check(32'h0000_0000, 1'b0);
    if (frame_count != 1) begin
      fail_now($sformatf("expected one serial frame, the monitor counted %0d", frame_count));
    end
    check_pins("adc3wire pins", pins_now(), pins_model(1'b0));
    mon_en = 1'b0;
  endtask

  initial begin
    seed            = 32'h34b1bf93;
    rst_n           = 1'b0;
    opb_abus        = '0;
    opb_be          = 4'h0;
    opb_dbus        = '0;
    opb_rnw         = 1'b0;
    opb_select      = 1'b0;
    adc0_roach2_rev = 2'b10;
    shadow_3w       = 32'h0;
    shadow_ctrl     = 32'h0;
    armed           = 1'b0;
    mon_en          = 1'b0;
    mon_shift       = 24'h0;
    exp_frame       = 24'h0;
    mon_bits        = 0;
    frame_count     = 0;
    repeat (8) tick();
    rst_n = 1'b1;
    tick();
    reset_state_checks();
    byte_write_sweep();
    bitbang_pins();
    control_strobes();
    serial_command();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== opb_adc16_ctrl.f ====
adc16_pkg.sv
opb_adc16_slave.sv
adc3wire_engine.sv
adc_strobe_gen.sv
opb_adc16_ctrl.sv
tb_opb_adc16_ctrl.sv

// ==== Makefile ====
# Verilator build and run for the opb adc16 controller.
VERILATOR ?= verilator
FILELIST  ?= opb_adc16_ctrl.f
TB_TOP    ?= tb_opb_adc16_ctrl
RTL_TOP   ?= opb_adc16_ctrl
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TB PASSED
VFLAGS    ?= --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
